// ==== flist.f ====
design/wb_bus_pkg.sv
design/ctrl_map_pkg.sv
design/setting_reg.sv
design/wb_decoder.sv
design/settings_bus.sv
design/ctrl_outputs.sv
design/readback_mux.sv
design/irq_ctrl.sv
design/u2_ctrl_core.sv
sim/u2_ctrl_core_props.sv
sim/tb_u2_ctrl_core.sv

// ==== Makefile ====
# Verilator build and run for the control core

VERILATOR  ?= verilator
TOP        ?= tb_u2_ctrl_core
RTL_TOP    ?= u2_ctrl_core
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL TESTS PASSED$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		design/wb_bus_pkg.sv design/ctrl_map_pkg.sv design/setting_reg.sv \
		design/wb_decoder.sv design/settings_bus.sv design/ctrl_outputs.sv \
		design/readback_mux.sv design/irq_ctrl.sv design/u2_ctrl_core.sv

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_u2_ctrl_core.sv ====
////////////////////
// Control core testbench
// Random bus traffic checked against a register model
////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_u2_ctrl_core;
   import wb_bus_pkg::*;
   import ctrl_map_pkg::*;

   localparam int CLK_NS  = 10;
   localparam int N_OPS   = 200;
   localparam int TMO_CYC = 8;

   logic        dsp_clk;
   logic        wb_rst;
   logic        cyc_i;
   logic        stb_i;
   logic        we_i;
   addr_t       adr_i;
   logic [3:0]  sel_i;
   word_t       dat_i;
   word_t       dat_o;
   logic        ack_o;
   logic        err_o;
   logic        sim_mode_i;
   logic [3:0]  clock_divider_i;
   logic        clk_status_i;
   logic        serdes_link_up_i;
   logic [15:0] irq_lines_i;
   logic        irq_o;
   logic [7:0]  leds_o;
   logic        clock_ready_o;
   logic [1:0]  clk_en_o;
   logic [1:0]  clk_sel_o;
   logic        ser_enable_o;
   logic        ser_prbsen_o;
   logic        ser_loopen_o;
   logic        ser_rx_en_o;
   logic        adc_oe_a_o;
   logic        adc_on_a_o;
   logic        adc_oe_b_o;
   logic        adc_on_b_o;
   logic        phy_resetn_o;

   // Register model
   logic [4:0]  exp_clock;
   logic [3:0]  exp_serdes;
   logic [3:0]  exp_adc;
   logic [7:0]  exp_led_sw;
   logic [7:0]  exp_led_src;
   logic        exp_phy;
   logic [15:0] exp_mask;
   logic [15:0] exp_pend;

   logic [15:0] lfsr_q;
   int          errors;
   int          checks;
   int          tests;
   int          failed_tests;
   int          test_start;
   word_t       r;
   word_t       d;
   word_t       rd;
   word_t       c0;
   word_t       c1;
   word_t       exp_w;
   logic [7:0]  sa;
   region_t     reg4;
   rb_idx_t     idx;
   logic        ak;
   logic        er;

   u2_ctrl_core u_u2_ctrl_core (.*);

   initial dsp_clk = 1'b0;
   always #(CLK_NS / 2) dsp_clk = ~dsp_clk;

   ////////////////////
   // Random bits
   // Taps 16 14 13 11
   function automatic logic next_bit();
      logic fb;
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      return fb;
   endfunction

   function automatic word_t rand_bits(input int n);
      word_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], next_bit()};
      end
      return v;
   endfunction

   function automatic addr_t set_adr(input logic [7:0] a);
      return {REGION_SETTINGS, 2'b00, a, 2'b00};
   endfunction

   function automatic addr_t rb_adr(input rb_idx_t i);
      return {REGION_READBACK, 6'd0, i, 2'b00};
   endfunction

   function automatic addr_t irq_adr(input logic w);
      return {REGION_IRQ, 9'd0, w, 2'b00};
   endfunction

   ////////////////////
   // Checks and bus access
   task automatic check_val(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %s: expected %h, got %h", name, exp, got);
      end
   endtask

   task automatic check_pins();
      logic [7:0] hw;
      logic [7:0] exp_leds;
      hw = {6'd0, clk_status_i, serdes_link_up_i};
      for (int b = 0; b < 8; b++) begin
         exp_leds[b] = exp_led_src[b] ? hw[b] : exp_led_sw[b];
      end
      check_val("clock_ready_o/clk_en_o/clk_sel_o",
                32'({clock_ready_o, clk_en_o, clk_sel_o}), 32'(exp_clock));
      check_val("ser_enable_o/prbsen/loopen/rx_en",
                32'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}), 32'(exp_serdes));
      check_val("adc_oe_a_o/on_a/oe_b/on_b",
                32'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}), 32'(exp_adc));
      check_val("phy_resetn_o", 32'(phy_resetn_o), 32'(!exp_phy));
      check_val("leds_o", 32'(leds_o), 32'(exp_leds));
   endtask

   // Holds the request until ack or err, then drops it
   task automatic bus_access(input logic we, input addr_t adr, input word_t wdata,
                             output word_t rdata, output logic acked, output logic erred);
      int n;
      @(negedge dsp_clk);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      dat_i = wdata;
      n = 0;
      while (!(ack_o || err_o) && n < TMO_CYC) begin
         @(negedge dsp_clk);
         n++;
      end
      acked = ack_o;
      erred = err_o;
      rdata = dat_o;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      checks++;
      if (!(acked || erred)) begin
         errors++;
         $display("No response from the bus at address %h", adr);
      end
   endtask

   task automatic bus_write(input addr_t adr, input word_t data);
      word_t x;
      logic  a;
      logic  e;
      bus_access(1'b1, adr, data, x, a, e);
      check_val("ack_o", 32'(a), 32'd1);
   endtask

   task automatic read_expect(input string name, input addr_t adr, input word_t exp);
      word_t x;
      logic  a;
      logic  e;
      bus_access(1'b0, adr, '0, x, a, e);
      check_val("ack_o", 32'(a), 32'd1);
      check_val(name, x, exp);
   endtask

   task automatic write_setting(input logic [7:0] a, input word_t data);
      bus_write(set_adr(a), data);
      // Pins still hold the old value in the ack cycle
      check_pins();
      case (a)
         SR_CLOCK:   exp_clock   = data[4:0];
         SR_SERDES:  exp_serdes  = data[3:0];
         SR_ADC:     exp_adc     = data[3:0];
         SR_LED_SW:  exp_led_sw  = data[7:0];
         SR_PHY:     exp_phy     = data[0];
         SR_LED_SRC: exp_led_src = data[7:0];
         default: ;
      endcase
      @(negedge dsp_clk);
      check_pins();
   endtask

   task automatic drive_lines(input logic [15:0] v);
      @(negedge dsp_clk);
      exp_pend    = exp_pend | (v & ~irq_lines_i);
      irq_lines_i = v;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors != test_start) begin
         failed_tests++;
      end
      $display("%-22s %s, %0d errors", name, (errors == test_start) ? "ok" : "failed",
               errors - test_start);
      test_start = errors;
   endtask

   ////////////////////
   // Test sequence
   initial begin
      lfsr_q           = 16'd8932;
      wb_rst           = 1'b1;
      cyc_i            = 1'b0;
      stb_i            = 1'b0;
      we_i             = 1'b0;
      adr_i            = '0;
      sel_i            = 4'hf;
      dat_i            = '0;
      sim_mode_i       = 1'b0;
      clock_divider_i  = 4'd0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      irq_lines_i      = '0;
      exp_clock        = '0;
      exp_serdes       = '0;
      exp_adc          = '0;
      exp_led_sw       = '0;
      exp_led_src      = '0;
      exp_phy          = 1'b0;
      exp_mask         = '0;
      exp_pend         = '0;
      errors           = 0;
      checks           = 0;
      tests            = 0;
      failed_tests     = 0;
      test_start       = 0;
      repeat (5) @(negedge dsp_clk);
      wb_rst = 1'b0;
      @(negedge dsp_clk);

      check_pins();
      check_val("irq_o", 32'(irq_o), 32'd0);
      end_test("reset state");

      // Mostly real setting addresses, some anywhere in the map
      for (int i = 0; i < 40; i++) begin
         r = rand_bits(1);
         if (r[0]) begin
            r = rand_bits(4);
         end else begin
            r = rand_bits(8);
         end
         sa = r[7:0];
         d  = rand_bits(32);
         write_setting(sa, d);
         if (i % 5 == 4) begin
            read_expect("dat_o settings read", set_adr(sa), 32'd0);
         end
      end
      end_test("setting writes");

      for (int i = 0; i < 16; i++) begin
         write_setting(SR_LED_SRC, rand_bits(32));
         write_setting(SR_LED_SW, rand_bits(32));
         r = rand_bits(2);
         @(negedge dsp_clk);
         clk_status_i     = r[1];
         serdes_link_up_i = r[0];
         @(negedge dsp_clk);
         check_pins();
      end
      end_test("led source select");

      r = rand_bits(5);
      @(negedge dsp_clk);
      sim_mode_i      = r[4];
      clock_divider_i = r[3:0];
      r = rand_bits(16);
      drive_lines(r[15:0]);
      for (int k = 0; k < 16; k++) begin
         idx = k[3:0];
         if (idx == RB_STRAPS) begin
            exp_w = {sim_mode_i, 27'd0, clock_divider_i};
         end else if (idx == RB_IRQ_LINES) begin
            exp_w = {16'd0, irq_lines_i};
         end else begin
            exp_w = '0;
         end
         if (idx != RB_CYCLES) begin
            read_expect("dat_o readback", rb_adr(idx), exp_w);
         end
      end
      bus_access(1'b0, rb_adr(RB_CYCLES), '0, c0, ak, er);
      bus_access(1'b0, rb_adr(RB_CYCLES), '0, c1, ak, er);
      checks++;
      if (c1 <= c0) begin
         errors++;
         $display("[ERROR] dat_o cycle count: first %h, second %h", c0, c1);
      end
      end_test("status readback");

      // Start from an empty pending word
      bus_write(irq_adr(IRQ_PEND_WORD), 32'h0000_ffff);
      exp_pend = '0;
      r = rand_bits(16);
      bus_write(irq_adr(IRQ_MASK_WORD), r);
      exp_mask = r[15:0];
      read_expect("dat_o irq mask", irq_adr(IRQ_MASK_WORD), {16'd0, exp_mask});
      for (int i = 0; i < 12; i++) begin
         r = rand_bits(16);
         drive_lines(r[15:0]);
         repeat (2) @(negedge dsp_clk);
         check_val("irq_o", 32'(irq_o), 32'(|(exp_pend & exp_mask)));
         read_expect("dat_o irq pending", irq_adr(IRQ_PEND_WORD), {16'd0, exp_pend});
         r = rand_bits(16);
         bus_write(irq_adr(IRQ_PEND_WORD), r);
         exp_pend = exp_pend & ~r[15:0];
         repeat (2) @(negedge dsp_clk);
         check_val("irq_o", 32'(irq_o), 32'(|(exp_pend & exp_mask)));
         read_expect("dat_o irq pending", irq_adr(IRQ_PEND_WORD), {16'd0, exp_pend});
         if (i % 4 == 3) begin
            r = rand_bits(16);
            bus_write(irq_adr(IRQ_MASK_WORD), r);
            exp_mask = r[15:0];
         end
      end
      end_test("interrupt controller");

      for (int i = 0; i < 8; i++) begin
         r    = rand_bits(4);
         reg4 = r[3:0];
         if (reg4 == REGION_READBACK || reg4 == REGION_SETTINGS || reg4 == REGION_IRQ) begin
            reg4 = reg4 ^ 4'h1;
         end
         r = rand_bits(12);
         d = rand_bits(32);
         c0 = rand_bits(1);
         bus_access(c0[0], {reg4, r[11:0]}, d, rd, ak, er);
         check_val("err_o", 32'(er), 32'd1);
         check_val("ack_o", 32'(ak), 32'd0);
      end
      @(negedge dsp_clk);
      check_pins();
      read_expect("dat_o irq pending", irq_adr(IRQ_PEND_WORD), {16'd0, exp_pend});
      end_test("unmapped regions");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // About 20 cycles per bus operation plus margin
   initial begin
      #(N_OPS * 20 * CLK_NS + 2000);
      $display("Watchdog expired before the tests finished");
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim/u2_ctrl_core_props.sv ====
////////////////////
// Bus protocol checks
// Response rules at the decoder master port
////////////////////
`timescale 1ns/100ps
`default_nettype none

module u2_ctrl_core_props (
   input wire dsp_clk,
   input wire wb_rst,
   input wire cyc_i,
   input wire stb_i,
   input wire ack_o,
   input wire err_o
);

   a_ack_err_excl: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      !(ack_o && err_o))
      else $error("ack and err high in the same cycle");

   // One-cycle responses, never back to back
   a_rsp_pulse: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      (ack_o || err_o) |=> !(ack_o || err_o))
      else $error("response held longer than one cycle");

   // No response without a request
   a_rsp_req: assert property (@(posedge dsp_clk) disable iff (wb_rst)
      $rose(ack_o || err_o) |-> $past(cyc_i && stb_i))
      else $error("response raised without a master strobe");

endmodule

bind wb_decoder u2_ctrl_core_props u_props (
   .dsp_clk(dsp_clk),
   .wb_rst(wb_rst),
   .cyc_i(cyc_i),
   .stb_i(stb_i),
   .ack_o(ack_o),
   .err_o(err_o)
);

`default_nettype wire

// ==== design/u2_ctrl_core.sv ====
////////////////////
// Control plane top level
// Bus decoder, settings, readback and interrupt slaves
////////////////////
`timescale 1ns/100ps
`default_nettype none

module u2_ctrl_core (
   input  wire                      dsp_clk,
   input  wire                      wb_rst,
   // Bus master port
   input  wire                      cyc_i,
   input  wire                      stb_i,
   input  wire                      we_i,
   input  wire wb_bus_pkg::addr_t   adr_i,
   input  wire [wb_bus_pkg::SW-1:0] sel_i,
   input  wire wb_bus_pkg::word_t   dat_i,
   output wb_bus_pkg::word_t        dat_o,
   output logic                     ack_o,
   output logic                     err_o,
   // Status inputs
   input  wire                      sim_mode_i,
   input  wire [3:0]                clock_divider_i,
   input  wire                      clk_status_i,
   input  wire                      serdes_link_up_i,
   input  wire ctrl_map_pkg::irq_vec_t irq_lines_i,
   // Pins
   output logic                     irq_o,
   output logic [7:0]               leds_o,
   output logic                     clock_ready_o,
   output logic [1:0]               clk_en_o,
   output logic [1:0]               clk_sel_o,
   output logic                     ser_enable_o,
   output logic                     ser_prbsen_o,
   output logic                     ser_loopen_o,
   output logic                     ser_rx_en_o,
   output logic                     adc_oe_a_o,
   output logic                     adc_on_a_o,
   output logic                     adc_oe_b_o,
   output logic                     adc_on_b_o,
   output logic                     phy_resetn_o
);
   import wb_bus_pkg::*;
   import ctrl_map_pkg::*;

   logic      s_we;
   addr_t     s_adr;
   word_t     s_dat;
   logic      rb_stb;
   logic      rb_ack;
   word_t     rb_dat;
   logic      sb_stb;
   logic      sb_ack;
   logic      ic_stb;
   logic      ic_ack;
   word_t     ic_dat;
   logic      set_stb;
   set_addr_t set_addr;
   word_t     set_data;

   ////////////////////
   // Bus fabric
   wb_decoder u_wb_decoder (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i), .adr_i(adr_i), .sel_i(sel_i),
      .dat_i(dat_i), .dat_o(dat_o), .ack_o(ack_o), .err_o(err_o),
      .s_we_o(s_we), .s_adr_o(s_adr), .s_dat_o(s_dat),
      .rb_stb_o(rb_stb), .rb_ack_i(rb_ack), .rb_dat_i(rb_dat),
      // Settings slave reads back zero
      .sb_stb_o(sb_stb), .sb_ack_i(sb_ack), .sb_dat_i('0),
      .ic_stb_o(ic_stb), .ic_ack_i(ic_ack), .ic_dat_i(ic_dat));

   ////////////////////
   // Slaves
   settings_bus u_settings_bus (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .stb_i(sb_stb), .we_i(s_we), .adr_i(s_adr), .dat_i(s_dat), .ack_o(sb_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   readback_mux u_readback_mux (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .stb_i(rb_stb), .adr_i(s_adr),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .irq_lines_i(irq_lines_i), .dat_o(rb_dat), .ack_o(rb_ack));

   irq_ctrl u_irq_ctrl (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .stb_i(ic_stb), .we_i(s_we), .adr_i(s_adr), .dat_i(s_dat),
      .dat_o(ic_dat), .ack_o(ic_ack),
      .irq_lines_i(irq_lines_i), .irq_o(irq_o));

   ////////////////////
   // Pin control
   ctrl_outputs u_ctrl_outputs (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .leds_o(leds_o), .clock_ready_o(clock_ready_o),
      .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_resetn_o(phy_resetn_o));

endmodule

`default_nettype wire

// ==== design/irq_ctrl.sv ====
////////////////////
// Interrupt controller
// Edge-latched pending bits, mask and write-one-to-clear
////////////////////
`timescale 1ns/100ps
`default_nettype none

module irq_ctrl (
   input  wire                      dsp_clk,
   input  wire                      wb_rst,
   input  wire                      stb_i,
   input  wire                      we_i,
   input  wire wb_bus_pkg::addr_t   adr_i,
   input  wire wb_bus_pkg::word_t   dat_i,
   output wb_bus_pkg::word_t        dat_o,
   output logic                     ack_o,
   input  wire ctrl_map_pkg::irq_vec_t irq_lines_i,
   output logic                     irq_o
);
   import wb_bus_pkg::*;
   import ctrl_map_pkg::*;

   irq_vec_t mask_q;
   irq_vec_t pend_q;
   irq_vec_t lines_q;
   irq_vec_t rise;
   irq_vec_t clr;
   logic     take;
   logic     word_sel;

   assign take     = stb_i & ~ack_o;
   assign word_sel = adr_i[WORD_LSB];

   // Low in the last sample, high now
   assign rise = irq_lines_i & ~lines_q;

   assign clr = (take && we_i && word_sel == IRQ_PEND_WORD) ? dat_i[IRQ_W-1:0] : '0;

   // Sampled through reset, so a line already high is not an edge
   always_ff @(posedge dsp_clk) begin
      lines_q <= irq_lines_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_o  <= 1'b0;
         mask_q <= '0;
         pend_q <= '0;
         irq_o  <= 1'b0;
      end else begin
         ack_o <= take;
         if (take && we_i && word_sel == IRQ_MASK_WORD) begin
            mask_q <= dat_i[IRQ_W-1:0];
         end
         // A fresh edge wins over a clear of the same bit
         pend_q <= (pend_q & ~clr) | rise;
         irq_o  <= |(pend_q & mask_q);
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (take) begin
         dat_o <= (word_sel == IRQ_PEND_WORD) ? word_t'(pend_q) : word_t'(mask_q);
      end
   end

endmodule

`default_nettype wire

// ==== design/readback_mux.sv ====
////////////////////
// Status readback window
// Sixteen read-only words, including a free-running cycle count
////////////////////
`timescale 1ns/100ps
`default_nettype none

module readback_mux (
   input  wire                      dsp_clk,
   input  wire                      wb_rst,
   input  wire                      stb_i,
   input  wire wb_bus_pkg::addr_t   adr_i,
   input  wire                      sim_mode_i,
   input  wire [3:0]                clock_divider_i,
   input  wire ctrl_map_pkg::irq_vec_t irq_lines_i,
   output wb_bus_pkg::word_t        dat_o,
   output logic                     ack_o
);
   import wb_bus_pkg::*;
   import ctrl_map_pkg::*;

   rb_idx_t rb_idx;
   word_t   rb_word;
   word_t   cycles_q;
   logic    take;

   assign rb_idx = adr_i[WORD_LSB +: RB_IW];
   assign take   = stb_i & ~ack_o;

   // Unlisted words read as zero
   always_comb begin
      case (rb_idx)
         RB_STRAPS:    rb_word = {sim_mode_i, {(DW-5){1'b0}}, clock_divider_i};
         RB_IRQ_LINES: rb_word = word_t'(irq_lines_i);
         RB_CYCLES:    rb_word = cycles_q;
         default:      rb_word = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_o    <= 1'b0;
         cycles_q <= '0;
      end else begin
         ack_o    <= take;
         cycles_q <= cycles_q + 1'b1;
      end
   end

   // Read data is captured with the ack
   always_ff @(posedge dsp_clk) begin
      if (take) begin
         dat_o <= rb_word;
      end
   end

endmodule

`default_nettype wire

// ==== design/ctrl_outputs.sv ====
////////////////////
// Pin control registers
// Clock, SERDES, ADC, PHY and LED pins from settings
////////////////////
`timescale 1ns/100ps
`default_nettype none

module ctrl_outputs (
   input  wire                      dsp_clk,
   input  wire                      wb_rst,
   input  wire                      set_stb_i,
   input  wire ctrl_map_pkg::set_addr_t set_addr_i,
   input  wire wb_bus_pkg::word_t   set_data_i,
   input  wire                      clk_status_i,
   input  wire                      serdes_link_up_i,
   output logic [7:0]               leds_o,
   output logic                     clock_ready_o,
   output logic [1:0]               clk_en_o,
   output logic [1:0]               clk_sel_o,
   output logic                     ser_enable_o,
   output logic                     ser_prbsen_o,
   output logic                     ser_loopen_o,
   output logic                     ser_rx_en_o,
   output logic                     adc_oe_a_o,
   output logic                     adc_on_a_o,
   output logic                     adc_oe_b_o,
   output logic                     adc_on_b_o,
   output logic                     phy_resetn_o
);
   import ctrl_map_pkg::*;

   clock_ctrl_t  clock_q;
   serdes_ctrl_t serdes_q;
   adc_ctrl_t    adc_q;
   phy_ctrl_t    phy_q;
   led_t         led_sw;
   led_t         led_src;
   led_t         led_hw;

   setting_reg #(.payload_t(clock_ctrl_t), .MY_ADDR(SR_CLOCK)) u_sr_clock (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(clock_q));

   setting_reg #(.payload_t(serdes_ctrl_t), .MY_ADDR(SR_SERDES)) u_sr_serdes (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(serdes_q));

   setting_reg #(.payload_t(adc_ctrl_t), .MY_ADDR(SR_ADC)) u_sr_adc (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(adc_q));

   setting_reg #(.payload_t(phy_ctrl_t), .MY_ADDR(SR_PHY)) u_sr_phy (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(phy_q));

   setting_reg #(.payload_t(led_t), .MY_ADDR(SR_LED_SW)) u_sr_led_sw (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(led_sw));

   setting_reg #(.payload_t(led_t), .MY_ADDR(SR_LED_SRC)) u_sr_led_src (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_stb_i(set_stb_i),
      .set_addr_i(set_addr_i), .set_data_i(set_data_i), .out_o(led_src));

   ////////////////////
   // Pin unpacking
   assign clock_ready_o = clock_q.ready;
   assign clk_en_o      = clock_q.clk_en;
   assign clk_sel_o     = clock_q.clk_sel;

   assign ser_enable_o = serdes_q.enable;
   assign ser_prbsen_o = serdes_q.prbsen;
   assign ser_loopen_o = serdes_q.loopen;
   assign ser_rx_en_o  = serdes_q.rx_en;

   assign adc_oe_a_o = adc_q.oe_a;
   assign adc_on_a_o = adc_q.on_a;
   assign adc_oe_b_o = adc_q.oe_b;
   assign adc_on_b_o = adc_q.on_b;

   // Cleared register leaves the PHY running
   assign phy_resetn_o = ~phy_q;

   ////////////////////
   // LEDs, source bit 1 picks hardware status
   assign led_hw = {6'd0, clk_status_i, serdes_link_up_i};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

// ==== design/settings_bus.sv ====
////////////////////
// Settings bus
// Turns bus writes into one-cycle settings strobes
////////////////////
`timescale 1ns/100ps
`default_nettype none

module settings_bus (
   input  wire                      dsp_clk,
   input  wire                      wb_rst,
   input  wire                      stb_i,
   input  wire                      we_i,
   input  wire wb_bus_pkg::addr_t   adr_i,
   input  wire wb_bus_pkg::word_t   dat_i,
   output logic                     ack_o,
   output logic                     set_stb_o,
   output ctrl_map_pkg::set_addr_t  set_addr_o,
   output wb_bus_pkg::word_t        set_data_o
);
   import wb_bus_pkg::*;
   import ctrl_map_pkg::*;

   logic take;

   // New access only, the strobe stays up while our ack is out
   assign take = stb_i & ~ack_o;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_o     <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         ack_o     <= take;
         set_stb_o <= take & we_i;
      end
   end

   // Address and data only matter under set_stb_o
   always_ff @(posedge dsp_clk) begin
      if (take & we_i) begin
         set_addr_o <= adr_i[WORD_LSB +: SET_AW];
         set_data_o <= dat_i;
      end
   end

endmodule

`default_nettype wire

// ==== design/wb_decoder.sv ====
////////////////////
// Single-master bus decoder
// Routes the strobe by region and returns data, ack or error
////////////////////
`timescale 1ns/100ps
`default_nettype none

module wb_decoder (
   input  wire                      dsp_clk,
   input  wire                      wb_rst,
   // Master side
   input  wire                      cyc_i,
   input  wire                      stb_i,
   input  wire                      we_i,
   input  wire wb_bus_pkg::addr_t   adr_i,
   input  wire [wb_bus_pkg::SW-1:0] sel_i,
   input  wire wb_bus_pkg::word_t   dat_i,
   output wb_bus_pkg::word_t        dat_o,
   output logic                     ack_o,
   output logic                     err_o,
   // Request shared by all slaves
   output logic                     s_we_o,
   output wb_bus_pkg::addr_t        s_adr_o,
   output wb_bus_pkg::word_t        s_dat_o,
   // Readback slave
   output logic                     rb_stb_o,
   input  wire                      rb_ack_i,
   input  wire wb_bus_pkg::word_t   rb_dat_i,
   // Settings slave
   output logic                     sb_stb_o,
   input  wire                      sb_ack_i,
   input  wire wb_bus_pkg::word_t   sb_dat_i,
   // Interrupt slave
   output logic                     ic_stb_o,
   input  wire                      ic_ack_i,
   input  wire wb_bus_pkg::word_t   ic_dat_i
);
   import wb_bus_pkg::*;

   region_t region;
   logic    req;
   logic    unmapped;

   assign region   = adr_i[DEC_HI:DEC_LO];
   assign req      = cyc_i & stb_i;
   assign unmapped = (region != REGION_READBACK) && (region != REGION_SETTINGS) &&
                     (region != REGION_IRQ);

   assign rb_stb_o = req && (region == REGION_READBACK);
   assign sb_stb_o = req && (region == REGION_SETTINGS);
   assign ic_stb_o = req && (region == REGION_IRQ);

   assign s_we_o  = we_i;
   assign s_adr_o = adr_i;

   // Slaves are word wide, so unselected byte lanes go out as zero
   always_comb begin
      for (int b = 0; b < SW; b++) begin
         s_dat_o[8*b +: 8] = sel_i[b] ? dat_i[8*b +: 8] : 8'h00;
      end
   end

   // Response path follows the held request address
   always_comb begin
      case (region)
         REGION_READBACK: begin
            dat_o = rb_dat_i;
            ack_o = rb_ack_i;
         end
         REGION_SETTINGS: begin
            dat_o = sb_dat_i;
            ack_o = sb_ack_i;
         end
         REGION_IRQ: begin
            dat_o = ic_dat_i;
            ack_o = ic_ack_i;
         end
         default: begin
            dat_o = '0;
            ack_o = 1'b0;
         end
      endcase
   end

   // Unmapped access answers with the same latency as a slave ack
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         err_o <= 1'b0;
      end else begin
         err_o <= req & unmapped & ~err_o;
      end
   end

endmodule

`default_nettype wire

// ==== design/setting_reg.sv ====
////////////////////
// Setting register
// Loads its payload from the settings strobe at its address
////////////////////
`timescale 1ns/100ps
`default_nettype none

module setting_reg #(
   parameter type                     payload_t = logic [7:0],
   parameter ctrl_map_pkg::set_addr_t MY_ADDR   = '0
) (
   input  wire                      dsp_clk,
   input  wire                      wb_rst,
   input  wire                      set_stb_i,
   input  wire ctrl_map_pkg::set_addr_t set_addr_i,
   input  wire wb_bus_pkg::word_t   set_data_i,
   output payload_t                 out_o
);
   import wb_bus_pkg::*;
   import ctrl_map_pkg::*;

   localparam int PW = $bits(payload_t);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == MY_ADDR);

   // Payload sits in the low bits of the data word
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         out_o <= payload_t'(0);
      end else if (hit) begin
         out_o <= payload_t'(set_data_i[PW-1:0]);
      end
   end

endmodule

`default_nettype wire

// ==== design/ctrl_map_pkg.sv ====
////////////////////
// Control register map
// Setting addresses, payload layouts, readback words, interrupt lines
////////////////////
`default_nettype none

package ctrl_map_pkg;

   localparam int SET_AW = 8;
   typedef logic [SET_AW-1:0] set_addr_t;

   // Setting register addresses
   localparam set_addr_t SR_CLOCK   = 0;
   localparam set_addr_t SR_SERDES  = 1;
   localparam set_addr_t SR_ADC     = 2;
   localparam set_addr_t SR_LED_SW  = 3;
   localparam set_addr_t SR_PHY     = 4;
   localparam set_addr_t SR_LED_SRC = 8;

   // Payloads, MSB first as they sit in the data word
   typedef struct packed {
      logic       ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef logic [7:0] led_t;

   // High holds the PHY in reset
   typedef logic phy_ctrl_t;

   ////////////////////
   // Readback window
   localparam int RB_IW = 4;
   typedef logic [RB_IW-1:0] rb_idx_t;

   localparam rb_idx_t RB_STRAPS    = 9;
   localparam rb_idx_t RB_IRQ_LINES = 13;
   localparam rb_idx_t RB_CYCLES    = 15;

   ////////////////////
   // Interrupt controller
   localparam int IRQ_W = 16;
   typedef logic [IRQ_W-1:0] irq_vec_t;

   localparam logic IRQ_MASK_WORD = 1'b0;
   localparam logic IRQ_PEND_WORD = 1'b1;

endpackage

`default_nettype wire

// ==== design/wb_bus_pkg.sv ====
////////////////////
// Control bus definitions
// Widths, region decode field and slave region codes
////////////////////
`default_nettype none

package wb_bus_pkg;

   // Bus widths
   localparam int DW = 32;
   localparam int AW = 16;
   localparam int SW = 4;

   typedef logic [DW-1:0] word_t;
   typedef logic [AW-1:0] addr_t;

   // Top nibble of the byte address picks the slave
   localparam int DEC_HI = 15;
   localparam int DEC_LO = 12;
   localparam int RW     = DEC_HI - DEC_LO + 1;

   typedef logic [RW-1:0] region_t;

   localparam region_t REGION_READBACK = 5;
   localparam region_t REGION_SETTINGS = 7;
   localparam region_t REGION_IRQ      = 8;

   // Word index starts above the byte offset
   localparam int WORD_LSB = 2;

endpackage

`default_nettype wire
